// ==== source/ctrl_consts.svh ====
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

// Field widths
`define CTRL_INSTR_W 32
`define CTRL_COND_W  4
`define CTRL_FLAGS_W 4
`define CTRL_ALU_W   4
`define CTRL_MULT_W  3

// Condition codes in instruction bits 31:28
`define COND_EQ 4'b0000
`define COND_NE 4'b0001
`define COND_CS 4'b0010
`define COND_CC 4'b0011
`define COND_MI 4'b0100
`define COND_PL 4'b0101
`define COND_VS 4'b0110
`define COND_VC 4'b0111
`define COND_HI 4'b1000
`define COND_LS 4'b1001
`define COND_GE 4'b1010
`define COND_LT 4'b1011
`define COND_GT 4'b1100
`define COND_LE 4'b1101
`define COND_AL 4'b1110

// Op field in instruction bits 27:26
`define OP_DATA   2'b00
`define OP_MEM    2'b01
`define OP_BRANCH 2'b10

`define ALU_ADD    4'b0100 // Address and target adds
`define MUL_NIBBLE 4'b1001 // Bits 7:4 of a multiply
`define BX_OPCODE  4'b1001 // Bits 24:21 of BX
`define PC_REG     4'd15

`endif

// ==== source/ctrl_pkg.sv ====
`default_nettype none

`include "ctrl_consts.svh"

package ctrl_pkg;

  // One fetched instruction
  typedef logic [`CTRL_INSTR_W-1:0] instrT;

  typedef logic [`CTRL_COND_W-1:0] condT;

  // N Z C V with N in bit 3
  typedef logic [`CTRL_FLAGS_W-1:0] flagsT;

  typedef logic [`CTRL_ALU_W-1:0] aluCtrlT;   // From bits 24:21
  typedef logic [`CTRL_MULT_W-1:0] multCtrlT; // From bits 23:21

  // Register or immediate source select
  typedef logic [1:0] srcSelT;

  // Bit 1 enables N and Z
  // Bit 0 enables C and V
  typedef logic [1:0] flagWriteT;

endpackage

`default_nettype wire

// ==== source/instrDecoder.sv ====
`default_nettype none

`include "ctrl_consts.svh"

module instrDecoder (
  input  ctrl_pkg::instrT     instrD,
  output ctrl_pkg::srcSelT    regSrcD,
  output ctrl_pkg::srcSelT    immSrcD,
  output logic                aluSrcD,
  output logic                memToRegD,
  output logic                regWriteD,
  output logic                memWriteD,
  output logic                branchD,
  output logic                multSelectD,
  output logic                bxInstrD,
  output logic                pcSrcD,
  output ctrl_pkg::aluCtrlT   aluControlD,
  output ctrl_pkg::multCtrlT  multControlD,
  output ctrl_pkg::flagWriteT flagWriteD
);

  logic       aluOpD;  // Data processing and multiply
  logic [1:0] opField;
  logic [3:0] rdField;
  logic       immBit;
  logic       sBit;
  logic       isMult;
  logic       isBx;

  assign opField = instrD[27:26];
  assign rdField = instrD[15:12];
  assign immBit  = instrD[25];
  assign sBit    = instrD[20];  // L bit for LDR and STR
  assign isMult  = (instrD[7:4] == `MUL_NIBBLE);
  assign isBx    = (instrD[24:21] == `BX_OPCODE) && (rdField == `PC_REG);

  // Control table by class
  always_comb begin
    regSrcD     = 2'd0;
    immSrcD     = 2'd0;
    aluSrcD     = 1'b0;
    memToRegD   = 1'b0;
    regWriteD   = 1'b0;
    memWriteD   = 1'b0;
    branchD     = 1'b0;
    aluOpD      = 1'b0;
    multSelectD = 1'b0;
    bxInstrD    = 1'b0;
    case (opField)
      `OP_DATA: begin
        if (immBit) begin
          aluSrcD   = 1'b1;
          regWriteD = 1'b1;
          aluOpD    = 1'b1;
        end else if (isMult) begin
          regWriteD   = 1'b1;
          aluOpD      = 1'b1;
          multSelectD = 1'b1;
        end else if (isBx) begin
          regSrcD  = 2'd1;  // Target comes from Rm
          branchD  = 1'b1;
          bxInstrD = 1'b1;
        end else begin
          regWriteD = 1'b1;
          aluOpD    = 1'b1;
        end
      end
      `OP_MEM: begin
        immSrcD = 2'd1;  // 12-bit offset
        aluSrcD = 1'b1;
        if (sBit) begin
          memToRegD = 1'b1;
          regWriteD = 1'b1;
        end else begin
          regSrcD   = 2'd2;  // Read Rd as store data
          memWriteD = 1'b1;
        end
      end
      `OP_BRANCH: begin
        regSrcD = 2'd1;
        immSrcD = 2'd2;  // 24-bit word offset
        aluSrcD = 1'b1;
        branchD = 1'b1;
      end
      // Op field 11 stays all zero
      default: ;
    endcase
  end

  always_comb begin
    if (aluOpD) begin
      aluControlD = instrD[24:21];
      flagWriteD  = {sBit, sBit};
    end else begin
      aluControlD = `ALU_ADD;
      flagWriteD  = 2'b00;
    end
  end

  assign multControlD = instrD[23:21];

  // Any write to R15 or any branch redirects fetch
  assign pcSrcD = (regWriteD && (rdField == `PC_REG)) || branchD;

endmodule

`default_nettype wire

// ==== source/condUnit.sv ====
`default_nettype none

`include "ctrl_consts.svh"

module condUnit (
  input  logic                clk,
  input  logic                arstN,
  input  logic                stallE,
  input  ctrl_pkg::condT      condE,
  input  ctrl_pkg::flagsT     flagsE,     // ALU flags of this instruction
  input  ctrl_pkg::flagWriteT flagWriteE,
  input  logic                branchE,
  input  logic                regWriteE,
  input  logic                memWriteE,
  input  logic                pcSrcE,
  output logic                branchTakenE,
  output logic                regWriteGatedE,
  output logic                memWriteGatedE,
  output logic                pcSrcGatedE,
  output logic                prevCarryE
);

  ctrl_pkg::flagsT flagsQ;  // Stored NZCV
  ctrl_pkg::flagsT flagsNext;
  logic            condExE;
  logic            flagN;
  logic            flagZ;
  logic            flagC;
  logic            flagV;

  assign {flagN, flagZ, flagC, flagV} = flagsQ;

  // Condition check against the stored flags
  always_comb begin
    case (condE)
      `COND_EQ: condExE = flagZ;
      `COND_NE: condExE = ~flagZ;
      `COND_CS: condExE = flagC;
      `COND_CC: condExE = ~flagC;
      `COND_MI: condExE = flagN;
      `COND_PL: condExE = ~flagN;
      `COND_VS: condExE = flagV;
      `COND_VC: condExE = ~flagV;
      `COND_HI: condExE = flagC & ~flagZ;
      `COND_LS: condExE = ~flagC | flagZ;
      `COND_GE: condExE = (flagN == flagV);
      `COND_LT: condExE = (flagN != flagV);
      `COND_GT: condExE = ~flagZ & (flagN == flagV);
      `COND_LE: condExE = flagZ | (flagN != flagV);
      `COND_AL: condExE = 1'b1;
      default:  condExE = 1'b0;  // Code 1111 never executes
    endcase
  end

  // Only an executed instruction updates its enabled flag pairs
  always_comb begin
    flagsNext = flagsQ;
    if (condExE) begin
      if (flagWriteE[1])
        flagsNext[3:2] = flagsE[3:2];
      if (flagWriteE[0])
        flagsNext[1:0] = flagsE[1:0];
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flagsQ <= '0;
    end else if (!stallE) begin
      flagsQ <= flagsNext;
    end
  end

  assign branchTakenE   = branchE & condExE;
  assign regWriteGatedE = regWriteE & condExE;
  assign memWriteGatedE = memWriteE & condExE;
  assign pcSrcGatedE    = pcSrcE & condExE;

  assign prevCarryE = flagC;  // Carry in for ADC and SBC

endmodule

`default_nettype wire

// ==== source/pipeRegs.sv ====
`default_nettype none

module pipeRegs (
  input  logic                clk,
  input  logic                arstN,
  input  logic                stallE,
  input  logic                flushE,
  input  logic                stallM,
  input  logic                stallW,
  input  logic                flushW,
  input  logic                aluSrcD,
  input  logic                memToRegD,
  input  logic                regWriteD,
  input  logic                memWriteD,
  input  logic                branchD,
  input  logic                multSelectD,
  input  logic                bxInstrD,
  input  logic                pcSrcD,
  input  ctrl_pkg::aluCtrlT   aluControlD,
  input  ctrl_pkg::multCtrlT  multControlD,
  input  ctrl_pkg::flagWriteT flagWriteD,
  input  ctrl_pkg::condT      condD,
  input  logic                memWriteGatedE,
  input  logic                regWriteGatedE,
  input  logic                pcSrcGatedE,
  output logic                aluSrcE,
  output ctrl_pkg::aluCtrlT   aluControlE,
  output ctrl_pkg::multCtrlT  multControlE,
  output logic                memToRegE,
  output ctrl_pkg::flagWriteT flagWriteE,
  output logic                branchE,
  output logic                regWriteE,
  output logic                memWriteE,
  output logic                pcSrcE,
  output logic                bxInstrE,
  output logic                multSelectE,
  output ctrl_pkg::condT      condE,
  output logic                memWriteM,
  output logic                memToRegM,
  output logic                regWriteM,
  output logic                pcSrcM,
  output logic                memToRegW,
  output logic                regWriteW,
  output logic                pcSrcW,
  output logic                pcWrPendingF
);

  // Execute controls that a flush turns into a bubble
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {regWriteE, memWriteE, branchE, pcSrcE, memToRegE, bxInstrE} <= '0;
      flagWriteE <= '0;
    end else if (flushE) begin
      {regWriteE, memWriteE, branchE, pcSrcE, memToRegE, bxInstrE} <= '0;
      flagWriteE <= '0;
    end else if (!stallE) begin
      {regWriteE, memWriteE, branchE, pcSrcE, memToRegE, bxInstrE} <=
        {regWriteD, memWriteD, branchD, pcSrcD, memToRegD, bxInstrD};
      flagWriteE <= flagWriteD;
    end
  end

  // Datapath selects pass through a flush unchanged
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {aluSrcE, multSelectE} <= '0;
      aluControlE  <= '0;
      multControlE <= '0;
      condE        <= '0;
    end else if (!stallE) begin
      {aluSrcE, multSelectE} <= {aluSrcD, multSelectD};
      aluControlE  <= aluControlD;
      multControlE <= multControlD;
      condE        <= condD;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {memWriteM, memToRegM, regWriteM, pcSrcM} <= '0;
    end else if (!stallM) begin
      {memWriteM, memToRegM, regWriteM, pcSrcM} <=
        {memWriteGatedE, memToRegE, regWriteGatedE, pcSrcGatedE};
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {memToRegW, regWriteW, pcSrcW} <= '0;
    end else if (flushW) begin
      {memToRegW, regWriteW, pcSrcW} <= '0;
    end else if (!stallW) begin
      {memToRegW, regWriteW, pcSrcW} <= {memToRegM, regWriteM, pcSrcM};
    end
  end

  assign pcWrPendingF = pcSrcD | pcSrcE | pcSrcM;  // PC write still in flight

endmodule

`default_nettype wire

// ==== source/controlUnit.sv ====
`default_nettype none

`include "ctrl_consts.svh"

module controlUnit (
  input  logic               clk,
  input  logic               arstN,
  input  ctrl_pkg::instrT    instrD,
  input  ctrl_pkg::flagsT    flagsE,
  input  logic               stallE,
  input  logic               flushE,
  input  logic               stallM,
  input  logic               stallW,
  input  logic               flushW,
  output ctrl_pkg::srcSelT   regSrcD,
  output ctrl_pkg::srcSelT   immSrcD,
  output logic               aluSrcE,
  output ctrl_pkg::aluCtrlT  aluControlE,
  output ctrl_pkg::multCtrlT multControlE,
  output logic               multSelectE,
  output logic               bxInstrE,
  output logic               branchTakenE,
  output logic               prevCarryE,
  output logic               memWriteM,
  output logic               memToRegM,
  output logic               regWriteM,  // Hazard unit
  output logic               memToRegE,  // Hazard unit
  output logic               memToRegW,
  output logic               regWriteW,
  output logic               pcSrcW,
  output logic               pcWrPendingF
);

  // Decode fields
  logic                aluSrcD;
  logic                memToRegD;
  logic                regWriteD;
  logic                memWriteD;
  logic                branchD;
  logic                multSelectD;
  logic                bxInstrD;
  logic                pcSrcD;
  ctrl_pkg::aluCtrlT   aluControlD;
  ctrl_pkg::multCtrlT  multControlD;
  ctrl_pkg::flagWriteT flagWriteD;

  // Execute fields before and after gating
  ctrl_pkg::flagWriteT flagWriteE;
  ctrl_pkg::condT      condE;
  logic                branchE;
  logic                regWriteE;
  logic                memWriteE;
  logic                pcSrcE;
  logic                regWriteGatedE;
  logic                memWriteGatedE;
  logic                pcSrcGatedE;
  logic                pcSrcM;

  instrDecoder decoderInst (
    .instrD, .regSrcD, .immSrcD, .aluSrcD, .memToRegD, .regWriteD, .memWriteD,
    .branchD, .multSelectD, .bxInstrD, .pcSrcD, .aluControlD, .multControlD,
    .flagWriteD
  );

  condUnit condUnitInst (
    .clk, .arstN, .stallE, .condE, .flagsE, .flagWriteE, .branchE, .regWriteE,
    .memWriteE, .pcSrcE, .branchTakenE, .regWriteGatedE, .memWriteGatedE,
    .pcSrcGatedE, .prevCarryE
  );

  pipeRegs pipeRegsInst (
    .clk, .arstN, .stallE, .flushE, .stallM, .stallW, .flushW,
    .aluSrcD, .memToRegD, .regWriteD, .memWriteD, .branchD, .multSelectD,
    .bxInstrD, .pcSrcD, .aluControlD, .multControlD, .flagWriteD,
    .condD          (instrD[`CTRL_INSTR_W-1 -: `CTRL_COND_W]),  // Bits 31:28
    .memWriteGatedE, .regWriteGatedE, .pcSrcGatedE,
    .aluSrcE, .aluControlE, .multControlE, .memToRegE, .flagWriteE, .branchE,
    .regWriteE, .memWriteE, .pcSrcE, .bxInstrE, .multSelectE, .condE,
    .memWriteM, .memToRegM, .regWriteM, .pcSrcM,
    .memToRegW, .regWriteW, .pcSrcW, .pcWrPendingF
  );

endmodule

`default_nettype wire

// ==== tb/controlUnit_properties.sv ====
`default_nettype none

module controlUnit_properties (
  input logic clk,
  input logic arstN,
  input logic flushE,
  input logic regWriteE,
  input logic branchE,
  input logic pcSrcGatedE,
  input logic branchTakenE,
  input logic aluSrcE,
  input logic multSelectE,
  input logic prevCarryE,
  input ctrl_pkg::aluCtrlT aluControlE,
  input ctrl_pkg::multCtrlT multControlE,
  input logic memWriteM,
  input logic memToRegM,
  input logic regWriteM,
  input logic memToRegE,
  input logic bxInstrE,
  input logic memToRegW,
  input logic regWriteW,
  input logic pcSrcW
);
  timeunit 1ns;
  timeprecision 1ps;

  int failCount = 0;  // Failed assertions so far

  // Stage registers and flags stay cleared through reset and the cycle after it
  resetQuiet: assert property (@(posedge clk) !arstN |=>
      !(memWriteM | memToRegM | regWriteM | memToRegE | bxInstrE |
        memToRegW | regWriteW | pcSrcW | branchTakenE |
        aluSrcE | multSelectE | prevCarryE) &&
      aluControlE == '0 && multControlE == '0)
    else begin
      $error("Control output active during or after reset");
      failCount++;
    end

  // A flushed instruction leaves a bubble in execute
  flushBubble: assert property (@(posedge clk) disable iff (!arstN)
      flushE |=> !regWriteE)
    else begin
      $error("regWriteE set after flushE");
      failCount++;
    end

  // A taken branch passed its condition, so the gated PC write follows too
  takenNeedsCond: assert property (@(posedge clk) disable iff (!arstN)
      branchTakenE |-> (branchE && pcSrcGatedE))
    else begin
      $error("branchTakenE without a passing condition");
      failCount++;
    end

endmodule

`default_nettype wire

// ==== tb/controlUnit_tb.sv ====
`default_nettype none

`include "ctrl_consts.svh"

module controlUnit_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int resetCycles  = 4;
  localparam int randomCycles = 400;
  localparam int directedCycles = 16 * 31 + 64;
  localparam int timeoutLimit = resetCycles + directedCycles + randomCycles + 50;

  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       aluSrc, memToReg, regWrite, memWrite, branch, aluOp, multSel, bx;
    logic [3:0] aluCtrl;
    logic [1:0] flagWrite;
    logic [2:0] multCtrl;
    logic       pcSrc;
    logic       condPass;
  } rowT;

  logic clk;
  logic arstN;
  ctrl_pkg::instrT instrD;
  ctrl_pkg::flagsT flagsE;
  logic stallE, flushE, stallM, stallW, flushW;
  ctrl_pkg::srcSelT regSrcD, immSrcD;
  logic aluSrcE, multSelectE, bxInstrE, branchTakenE, prevCarryE;
  ctrl_pkg::aluCtrlT aluControlE;
  ctrl_pkg::multCtrlT multControlE;
  logic memWriteM, memToRegM, regWriteM, memToRegE;
  logic memToRegW, regWriteW, pcSrcW, pcWrPendingF;

  int seed = 32'h1810_e1c7;
  int errors = 0;
  int checks = 0;
  int cycleCount = 0;

  // Model pipeline state
  ctrl_pkg::instrT eInstr;
  logic            eValid;
  logic [3:0]      mFlags;
  logic [3:0]      mStage;  // memWrite memToReg regWrite pcSrc
  logic [2:0]      wStage;  // memToReg regWrite pcSrc

  controlUnit controlUnit_inst (.*);

  bind controlUnit controlUnit_properties propsInst (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic condRef(input logic [3:0] cond, input logic [3:0] f);
    logic n, z, c, v;
    {n, z, c, v} = f;
    case (cond)
      `COND_EQ: return z;
      `COND_NE: return !z;
      `COND_CS: return c;
      `COND_CC: return !c;
      `COND_MI: return n;
      `COND_PL: return !n;
      `COND_VS: return v;
      `COND_VC: return !v;
      `COND_HI: return c && !z;
      `COND_LS: return !c || z;
      `COND_GE: return n == v;
      `COND_LT: return n != v;
      `COND_GT: return !z && (n == v);
      `COND_LE: return z || (n != v);
      `COND_AL: return 1'b1;
      default:  return 1'b0;
    endcase
  endfunction

  // Expected control table row plus condition result
  function automatic rowT refRow(input ctrl_pkg::instrT ins, input logic [3:0] f);
    rowT r;
    r = '0;
    case (ins[27:26])
      2'b00: begin
        if (ins[25]) begin
          r.aluSrc = 1;
          r.regWrite = 1;
          r.aluOp = 1;
        end else if (ins[7:4] == 4'b1001) begin
          r.regWrite = 1;
          r.aluOp = 1;
          r.multSel = 1;
        end else if (ins[24:21] == 4'b1001 && ins[15:12] == 4'd15) begin
          r.regSrc = 1;
          r.branch = 1;
          r.bx = 1;
        end else begin
          r.regWrite = 1;
          r.aluOp = 1;
        end
      end
      2'b01: begin
        r.immSrc = 1;
        r.aluSrc = 1;
        if (ins[20]) begin
          r.memToReg = 1;
          r.regWrite = 1;
        end else begin
          r.regSrc = 2;
          r.memWrite = 1;
        end
      end
      2'b10: begin
        r.regSrc = 1;
        r.immSrc = 2;
        r.aluSrc = 1;
        r.branch = 1;
      end
      default: ;
    endcase
    r.aluCtrl = r.aluOp ? ins[24:21] : 4'd4;
    r.flagWrite = r.aluOp ? {ins[20], ins[20]} : 2'b00;
    r.multCtrl = ins[23:21];
    r.pcSrc = (r.regWrite && ins[15:12] == 4'd15) || r.branch;
    r.condPass = condRef(ins[31:28], f);
    return r;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // Compare against the model, then advance the model by one edge
  always @(posedge clk) begin
    rowT rowD;
    rowT rowE;
    logic pass;
    if (!arstN) begin
      eInstr = '0;
      eValid = 0;
      mFlags = '0;
      mStage = '0;
      wStage = '0;
    end else begin
      rowD = refRow(instrD, mFlags);
      rowE = refRow(eInstr, mFlags);
      pass = eValid && rowE.condPass;
      check("regSrcD", regSrcD, rowD.regSrc);
      check("immSrcD", immSrcD, rowD.immSrc);
      check("pcWrPendingF", pcWrPendingF, rowD.pcSrc | (eValid & rowE.pcSrc) | mStage[0]);
      check("aluSrcE", aluSrcE, rowE.aluSrc);
      check("aluControlE", aluControlE, rowE.aluCtrl);
      check("multControlE", multControlE, rowE.multCtrl);
      check("multSelectE", multSelectE, rowE.multSel);
      check("bxInstrE", bxInstrE, eValid & rowE.bx);
      check("memToRegE", memToRegE, eValid & rowE.memToReg);
      check("branchTakenE", branchTakenE, pass & rowE.branch);
      check("prevCarryE", prevCarryE, mFlags[1]);
      check("memWriteM", memWriteM, mStage[3]);
      check("memToRegM", memToRegM, mStage[2]);
      check("regWriteM", regWriteM, mStage[1]);
      check("memToRegW", memToRegW, wStage[2]);
      check("regWriteW", regWriteW, wStage[1]);
      check("pcSrcW", pcSrcW, wStage[0]);
      if (flushW)
        wStage = '0;
      else if (!stallW)
        wStage = mStage[2:0];
      if (!stallM)
        mStage = {pass & rowE.memWrite, eValid & rowE.memToReg,
                  pass & rowE.regWrite, pass & rowE.pcSrc};
      if (!stallE && pass) begin
        if (rowE.flagWrite[1])
          mFlags[3:2] = flagsE[3:2];
        if (rowE.flagWrite[0])
          mFlags[1:0] = flagsE[1:0];
      end
      if (!stallE)
        eInstr = instrD;
      if (flushE)
        eValid = 0;
      else if (!stallE)
        eValid = 1;
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > timeoutLimit) begin
      $display("Timeout after %0d cycles, stimulus never finished", cycleCount);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic ctrl_pkg::instrT dpInstr(input logic [3:0] c, input logic imm,
                                              input logic [3:0] opc, input logic s,
                                              input logic [3:0] rd);
    return {c, 2'b00, imm, opc, s, 4'd1, rd, 12'h002};
  endfunction

  task automatic applyCycle(input ctrl_pkg::instrT ins, input logic [3:0] f,
                            input logic stE = 0, input logic flE = 0, input logic stM = 0,
                            input logic stW = 0, input logic flW = 0);
    @(negedge clk);
    instrD = ins;
    flagsE = f;
    stallE = stE;
    flushE = flE;
    stallM = stM;
    stallW = stW;
    flushW = flW;
  endtask

  initial begin
    ctrl_pkg::instrT nop;
    ctrl_pkg::instrT randInstr;
    logic [31:0] randFlags;
    logic [31:0] r;
    nop = {`COND_AL, 2'b11, 26'h0};  // Undefined op, decodes to nothing
    arstN = 0;
    instrD = nop;
    flagsE = '0;
    {stallE, flushE, stallM, stallW, flushW} = '0;
    repeat (resetCycles) @(negedge clk);
    arstN = 1;
    // Every class once, plus a write to R15
    applyCycle(dpInstr(`COND_AL, 1, 4'b0100, 1, 4'd3), 4'b1010);
    applyCycle(dpInstr(`COND_AL, 0, 4'b0010, 0, 4'd4), 4'b0000);
    applyCycle({`COND_AL, 6'b000000, 2'b01, 4'd6, 4'd2, 4'd3, 4'b1001, 4'd4}, 4'h0);
    applyCycle({`COND_AL, 8'h12, 12'hFFF, 4'h1, 4'd14}, 4'h0);
    applyCycle({`COND_AL, 8'h59, 4'd2, 4'd7, 12'h004}, 4'h0);
    applyCycle({`COND_AL, 8'h58, 4'd2, 4'd7, 12'h004}, 4'h0);
    applyCycle({`COND_AL, 4'b1010, 24'h000010}, 4'h0);
    applyCycle({`COND_AL, 2'b11, 26'h155_5555}, 4'h0);
    applyCycle(dpInstr(`COND_AL, 0, 4'b1101, 0, 4'd15), 4'h0);
    repeat (3) applyCycle(nop, 4'h0);
    // Every condition code against every flag value
    for (int f = 0; f < 16; f++) begin
      applyCycle(dpInstr(`COND_AL, 1, 4'b1010, 1, 4'd0), f[3:0]);
      for (int c = 0; c < 15; c++) begin
        applyCycle({c[3:0], 8'h58, 4'd2, 4'd7, 12'h004}, 4'hF);
        applyCycle(dpInstr(c[3:0], 0, 4'b0100, 0, 4'd5), 4'hF);
      end
    end
    // Failed condition leaves the flags alone
    applyCycle(dpInstr(`COND_AL, 1, 4'b1010, 1, 4'd0), 4'h0);
    applyCycle(dpInstr(`COND_EQ, 1, 4'b1010, 1, 4'd0), 4'hF);
    applyCycle(dpInstr(`COND_NE, 0, 4'b0100, 0, 4'd5), 4'h0);
    applyCycle(dpInstr(`COND_CS, 0, 4'b0100, 0, 4'd5), 4'h0);
    // Stalls and flushes
    applyCycle({`COND_AL, 8'h59, 4'd2, 4'd7, 12'h004}, 4'h0);
    applyCycle(dpInstr(`COND_AL, 0, 4'b0100, 0, 4'd5), 4'h0, 1, 0, 0, 0, 0);
    applyCycle(dpInstr(`COND_AL, 0, 4'b0100, 0, 4'd5), 4'h0, 1, 0, 1, 0, 0);
    applyCycle(nop, 4'h0, 0, 0, 1, 1, 0);
    applyCycle({`COND_AL, 8'h58, 4'd2, 4'd7, 12'h004}, 4'h0, 0, 0, 0, 1, 0);
    applyCycle(dpInstr(`COND_AL, 0, 4'b0100, 0, 4'd6), 4'h0, 0, 1, 0, 0, 0);
    applyCycle(nop, 4'h0);
    applyCycle(nop, 4'h0, 0, 0, 0, 0, 1);
    applyCycle(nop, 4'h0, 1, 1, 0, 0, 0);
    // PC writes in flight
    applyCycle({`COND_AL, 4'b1010, 24'h000010}, 4'h0);
    repeat (3) applyCycle(nop, 4'h0);
    applyCycle({`COND_AL, 8'h12, 12'hFFF, 4'h1, 4'd14}, 4'h0);
    repeat (3) applyCycle(nop, 4'h0);
    applyCycle(dpInstr(`COND_AL, 1, 4'b0100, 0, 4'd15), 4'h0);
    repeat (3) applyCycle(nop, 4'h0);
    // Random mix with occasional stalls and flushes
    for (int i = 0; i < randomCycles; i++) begin
      r = $random(seed);
      randInstr = $random(seed);
      randFlags = $random(seed);
      applyCycle(randInstr, randFlags[3:0], r[2:0] == 0, r[5:3] == 0,
                 r[8:6] == 0, r[11:9] == 0, r[14:12] == 0);
    end
    repeat (4) applyCycle(nop, 4'h0);
    @(negedge clk);
    errors += controlUnit_inst.propsInst.failCount;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+source
source/ctrl_pkg.sv
source/instrDecoder.sv
source/condUnit.sv
source/pipeRegs.sv
source/controlUnit.sv
tb/controlUnit_properties.sv
tb/controlUnit_tb.sv

// ==== Bender.yml ====
package:
  name: control_unit

export_include_dirs:
  - source

sources:
  - files:
      - source/ctrl_pkg.sv
      - source/instrDecoder.sv
      - source/condUnit.sv
      - source/pipeRegs.sv
      - source/controlUnit.sv
  - target: test
    files:
      - tb/controlUnit_properties.sv
      - tb/controlUnit_tb.sv
